// ==== include/ptw_defs.svh ====
/* Sv39 widths, PTE bit positions and page geometry for the page-table walker.
   Included by the package and by every block that slices addresses or PTEs */
`ifndef PTW_DEFS_SVH
`define PTW_DEFS_SVH

// ----------------------------------------------------------------------
// address widths
// ----------------------------------------------------------------------
`define PTW_VLEN  39
`define PTW_PLEN  56
`define PTW_PPNW  44
`define PTW_ASIDW 16

// 4 KiB pages, three 9-bit vpn slices above the offset
`define PTW_PGOFF 12
`define PTW_VPNW  9

// ----------------------------------------------------------------------
// pte layout
// ----------------------------------------------------------------------
`define PTW_PTE_V 0
`define PTW_PTE_R 1
`define PTW_PTE_W 2
`define PTW_PTE_X 3
`define PTW_PTE_U 4
`define PTW_PTE_G 5
`define PTW_PTE_A 6
`define PTW_PTE_D 7
`define PTW_PTE_PPN_LSB 10
// bits 63:54 are reserved and must read as zero
`define PTW_PTE_RSVD_LSB 54

`endif

// ==== design/ptw_pkg.sv ====
/* Shared vector types and the walk level enum of the Sv39 page-table walker.
   Referenced by scoped name from every block */
`include "ptw_defs.svh"

package ptw_pkg;

  // virtual address as seen by the tlbs
  typedef logic [`PTW_VLEN-1:0] vaddr_t;

  // physical address of a pte in memory
  typedef logic [`PTW_PLEN-1:0] paddr_t;

  // physical page number, from satp or from a pte
  typedef logic [`PTW_PPNW-1:0] ppn_t;

  // tlb tag, vaddr without the page offset
  typedef logic [`PTW_VLEN-`PTW_PGOFF-1:0] vpn_t;

  typedef logic [`PTW_ASIDW-1:0] asid_t;

  // raw 8-byte page-table entry
  typedef logic [63:0] pte_t;

  // sv39 walks at most three levels
  // LVL1 maps 1 GiB, LVL2 maps 2 MiB, LVL3 maps 4 KiB
  typedef enum logic [1:0] {
    LVL1,
    LVL2,
    LVL3
  } ptw_level_e;

endpackage

// ==== design/ptw_pte_checker.sv ====
/* Classifies a fetched PTE as pointer, leaf or page fault.
   Purely combinational, evaluated in the lookup cycle of the walk */
`include "ptw_defs.svh"

module ptw_pte_checker (
  input  ptw_pkg::pte_t       pte_i,
  input  ptw_pkg::ptw_level_e level_i,
  input  logic                is_instr_i,
  input  logic                is_store_i,
  input  logic                mxr_i,
  output logic                leaf_o,
  output logic                fault_o
);

  logic          v;
  logic          r;
  logic          w;
  logic          x;
  logic          u;
  logic          a;
  logic          d;
  ptw_pkg::ppn_t ppn;
  logic          bad_encoding;
  logic          misaligned;
  logic          instr_fault;
  logic          data_fault;
  logic          leaf_fault;
  logic          ptr_fault;

  assign v   = pte_i[`PTW_PTE_V];
  assign r   = pte_i[`PTW_PTE_R];
  assign w   = pte_i[`PTW_PTE_W];
  assign x   = pte_i[`PTW_PTE_X];
  assign u   = pte_i[`PTW_PTE_U];
  assign a   = pte_i[`PTW_PTE_A];
  assign d   = pte_i[`PTW_PTE_D];
  assign ppn = pte_i[`PTW_PTE_PPN_LSB +: `PTW_PPNW];

  // invalid, write-only or reserved bits set, whatever the level
  assign bad_encoding = ~v | (w & ~r) | (|pte_i[63:`PTW_PTE_RSVD_LSB]);

  // r or x marks a leaf, otherwise it points to the next table
  assign leaf_o = r | x;

  // ----------------------------------------------------------------------
  // leaf checks
  // ----------------------------------------------------------------------
  // a and d are managed by software, so a missing bit faults
  assign instr_fault = ~x | ~a;

  // mxr makes execute-only pages readable
  assign data_fault = ~a | ~(r | (x & mxr_i)) | (is_store_i & (~w | ~d));

  // superpage ppn must be aligned to its size
  assign misaligned = (level_i == ptw_pkg::LVL1) ? (|ppn[2*`PTW_VPNW-1:0]) :
                      (level_i == ptw_pkg::LVL2) ? (|ppn[`PTW_VPNW-1:0]) : 1'b0;

  assign leaf_fault = (is_instr_i ? instr_fault : data_fault) | misaligned;

  // pointer checks, a/d/u are reserved on non-leaf entries
  // and there is no table below LVL3
  assign ptr_fault = a | d | u | (level_i == ptw_pkg::LVL3);

  assign fault_o = bad_encoding | (leaf_o ? leaf_fault : ptr_fault);

endmodule

// ==== design/ptw_walk_ctrl.sv ====
/* Walk FSM of the page-table walker: miss arbitration, memory requests,
   pointer and level tracking, update and error pulses, flush draining */
`include "ptw_defs.svh"

module ptw_walk_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  logic                enable_translation_i,
  input  logic                en_ld_st_translation_i,
  input  logic                itlb_access_i,
  input  logic                itlb_hit_i,
  input  logic                dtlb_access_i,
  input  logic                dtlb_hit_i,
  input  ptw_pkg::vaddr_t     itlb_vaddr_i,
  input  ptw_pkg::vaddr_t     dtlb_vaddr_i,
  input  ptw_pkg::ppn_t       satp_ppn_i,
  input  logic                mem_gnt_i,
  input  logic                mem_rvalid_i,
  input  ptw_pkg::pte_t       mem_rdata_i,
  input  ptw_pkg::vaddr_t     vaddr_i,
  input  logic                walking_instr_i,
  input  logic                leaf_i,
  input  logic                fault_i,
  output logic                mem_req_o,
  output ptw_pkg::paddr_t     mem_addr_o,
  output ptw_pkg::pte_t       pte_o,
  output ptw_pkg::ptw_level_e level_o,
  output logic                start_o,
  output logic                start_instr_o,
  output ptw_pkg::vaddr_t     start_vaddr_o,
  output logic                pte_accept_o,
  output logic                ptw_active_o,
  output logic                ptw_error_o,
  output logic                itlb_miss_o,
  output logic                dtlb_miss_o,
  output logic                itlb_update_valid_o,
  output logic                dtlb_update_valid_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    PROPAGATE_ERROR,
    WAIT_RVALID
  } state_e;

  state_e              state_q;
  state_e              state_d;
  ptw_pkg::ptw_level_e level_q;
  ptw_pkg::ptw_level_e level_d;
  ptw_pkg::paddr_t     pptr_q;
  ptw_pkg::paddr_t     pptr_d;
  logic                rvalid_q;
  ptw_pkg::pte_t       rdata_q;
  ptw_pkg::ppn_t       pte_ppn;
  logic                itlb_miss;
  logic                dtlb_miss;

  // a data access in the same cycle holds off the instruction side
  assign itlb_miss = enable_translation_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;
  assign dtlb_miss = en_ld_st_translation_i & dtlb_access_i & ~dtlb_hit_i;

  assign start_vaddr_o = itlb_miss ? itlb_vaddr_i : dtlb_vaddr_i;
  assign pte_ppn       = rdata_q[`PTW_PTE_PPN_LSB +: `PTW_PPNW];
  assign pte_o         = rdata_q;
  assign level_o       = level_q;
  assign mem_addr_o    = pptr_q;
  assign ptw_active_o  = (state_q != IDLE);

  // ----------------------------------------------------------------------
  // walk FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d             = state_q;
    level_d             = level_q;
    pptr_d              = pptr_q;
    mem_req_o           = 1'b0;
    start_o             = 1'b0;
    start_instr_o       = 1'b0;
    pte_accept_o        = 1'b0;
    ptw_error_o         = 1'b0;
    itlb_miss_o         = 1'b0;
    dtlb_miss_o         = 1'b0;
    itlb_update_valid_o = 1'b0;
    dtlb_update_valid_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        // every walk starts at the root table
        level_d = ptw_pkg::LVL1;
        if (itlb_miss || dtlb_miss) begin
          start_o       = 1'b1;
          start_instr_o = itlb_miss;
          itlb_miss_o   = itlb_miss;
          dtlb_miss_o   = ~itlb_miss;
          // root pte address, satp ppn and vpn[2]
          pptr_d  = {satp_ppn_i, start_vaddr_o[`PTW_VLEN-1 -: `PTW_VPNW], 3'b000};
          state_d = WAIT_GRANT;
        end
      end

      WAIT_GRANT: begin
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          state_d = PTE_LOOKUP;
        end
      end

      PTE_LOOKUP: begin
        // response is registered, so evaluate on rvalid_q
        if (rvalid_q) begin
          if (fault_i) begin
            state_d = PROPAGATE_ERROR;
          end else begin
            pte_accept_o = 1'b1;
            if (leaf_i) begin
              itlb_update_valid_o = walking_instr_i;
              dtlb_update_valid_o = ~walking_instr_i;
              state_d             = IDLE;
            end else begin
              // pointer, descend one level with the next vpn slice
              state_d = WAIT_GRANT;
              if (level_q == ptw_pkg::LVL1) begin
                level_d = ptw_pkg::LVL2;
                pptr_d  = {pte_ppn, vaddr_i[`PTW_PGOFF+`PTW_VPNW +: `PTW_VPNW], 3'b000};
              end else begin
                level_d = ptw_pkg::LVL3;
                pptr_d  = {pte_ppn, vaddr_i[`PTW_PGOFF +: `PTW_VPNW], 3'b000};
              end
            end
          end
        end
      end

      PROPAGATE_ERROR: begin
        ptw_error_o = 1'b1;
        state_d     = IDLE;
      end

      // drain the response owed from before a flush
      WAIT_RVALID: begin
        if (rvalid_q) begin
          state_d = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // flush aborts the walk, but a granted request still owes a response
    if (flush_i) begin
      if ((state_q == PTE_LOOKUP && !rvalid_q) || (state_q == WAIT_GRANT && mem_gnt_i)) begin
        state_d = WAIT_RVALID;
      end else begin
        state_d = IDLE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      level_q  <= ptw_pkg::LVL1;
      pptr_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      level_q  <= level_d;
      pptr_q   <= pptr_d;
      rvalid_q <= mem_rvalid_i;
    end
  end

  // response data register
  always_ff @(posedge clk_i) begin
    rdata_q <= mem_rdata_i;
  end

  // the memory grants only a pending request
  a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_gnt_i |-> mem_req_o);

  // a response arrives only while the walker owes one
  a_rvalid_owed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rvalid_i |-> (state_q == PTE_LOOKUP || state_q == WAIT_RVALID));

endmodule

// ==== design/ptw_walk_context.sv ====
/* Holds the context of the walk in progress and forms the TLB update.
   Loaded on an accepted miss, accumulates the global bit per accepted PTE */
`include "ptw_defs.svh"

module ptw_walk_context (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic                start_instr_i,
  input  ptw_pkg::vaddr_t     start_vaddr_i,
  input  ptw_pkg::asid_t      asid_i,
  input  logic                pte_accept_i,
  input  ptw_pkg::pte_t       pte_i,
  input  ptw_pkg::ptw_level_e level_i,
  output ptw_pkg::vaddr_t     vaddr_o,
  output logic                walking_instr_o,
  output ptw_pkg::vpn_t       update_vpn_o,
  output ptw_pkg::asid_t      update_asid_o,
  output logic                update_is_2m_o,
  output logic                update_is_1g_o,
  output ptw_pkg::pte_t       update_content_o
);

  ptw_pkg::vaddr_t vaddr_q;
  ptw_pkg::asid_t  asid_q;
  logic            instr_q;
  logic            global_q;

  // instruction flag and global accumulator
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_q  <= 1'b0;
      global_q <= 1'b0;
    end else if (start_i) begin
      instr_q  <= start_instr_i;
      global_q <= 1'b0;
    end else if (pte_accept_i) begin
      // a global pointer makes the whole subtree global
      global_q <= global_q | pte_i[`PTW_PTE_G];
    end
  end

  // address and asid of the miss being served
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      vaddr_q <= start_vaddr_i;
      asid_q  <= asid_i;
    end
  end

  assign vaddr_o         = vaddr_q;
  assign walking_instr_o = instr_q;

  // ----------------------------------------------------------------------
  // tlb update
  // ----------------------------------------------------------------------
  assign update_vpn_o   = vaddr_q[`PTW_VLEN-1:`PTW_PGOFF];
  assign update_asid_o  = asid_q;
  assign update_is_1g_o = (level_i == ptw_pkg::LVL1);
  assign update_is_2m_o = (level_i == ptw_pkg::LVL2);

  always_comb begin
    update_content_o = pte_i;
    update_content_o[`PTW_PTE_G] = pte_i[`PTW_PTE_G] | global_q;
  end

  // starts only come from idle, never in a lookup cycle
  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(start_i && pte_accept_i));

endmodule

// ==== design/ptw_sv39.sv ====
/* Sv39 page-table walker top level serving instruction and data TLB misses.
   Connects the walk FSM, the PTE checker and the walk context */
module ptw_sv39 (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  input  logic            enable_translation_i,
  input  logic            en_ld_st_translation_i,
  input  logic            lsu_is_store_i,
  input  logic            mxr_i,
  input  ptw_pkg::asid_t  asid_i,
  input  ptw_pkg::ppn_t   satp_ppn_i,
  input  logic            itlb_access_i,
  input  logic            itlb_hit_i,
  input  logic            dtlb_access_i,
  input  logic            dtlb_hit_i,
  input  ptw_pkg::vaddr_t itlb_vaddr_i,
  input  ptw_pkg::vaddr_t dtlb_vaddr_i,
  input  logic            mem_gnt_i,
  input  logic            mem_rvalid_i,
  input  ptw_pkg::pte_t   mem_rdata_i,
  output logic            mem_req_o,
  output ptw_pkg::paddr_t mem_addr_o,
  output logic            ptw_active_o,
  output logic            walking_instr_o,
  output logic            ptw_error_o,
  output logic            itlb_miss_o,
  output logic            dtlb_miss_o,
  output logic            itlb_update_valid_o,
  output logic            dtlb_update_valid_o,
  output logic            update_is_2m_o,
  output logic            update_is_1g_o,
  output ptw_pkg::vpn_t   update_vpn_o,
  output ptw_pkg::asid_t  update_asid_o,
  output ptw_pkg::pte_t   update_content_o
);

  // registered pte and level under evaluation
  ptw_pkg::pte_t       pte;
  ptw_pkg::ptw_level_e level;
  // miss hand-off to the context
  logic                start;
  logic                start_instr;
  ptw_pkg::vaddr_t     start_vaddr;
  logic                pte_accept;
  // checker verdict
  logic                leaf;
  logic                fault;
  ptw_pkg::vaddr_t     walk_vaddr;

  ptw_walk_ctrl u_walk_ctrl (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .flush_i                (flush_i),
    .enable_translation_i   (enable_translation_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .itlb_access_i          (itlb_access_i),
    .itlb_hit_i             (itlb_hit_i),
    .dtlb_access_i          (dtlb_access_i),
    .dtlb_hit_i             (dtlb_hit_i),
    .itlb_vaddr_i           (itlb_vaddr_i),
    .dtlb_vaddr_i           (dtlb_vaddr_i),
    .satp_ppn_i             (satp_ppn_i),
    .mem_gnt_i              (mem_gnt_i),
    .mem_rvalid_i           (mem_rvalid_i),
    .mem_rdata_i            (mem_rdata_i),
    .vaddr_i                (walk_vaddr),
    .walking_instr_i        (walking_instr_o),
    .leaf_i                 (leaf),
    .fault_i                (fault),
    .mem_req_o              (mem_req_o),
    .mem_addr_o             (mem_addr_o),
    .pte_o                  (pte),
    .level_o                (level),
    .start_o                (start),
    .start_instr_o          (start_instr),
    .start_vaddr_o          (start_vaddr),
    .pte_accept_o           (pte_accept),
    .ptw_active_o           (ptw_active_o),
    .ptw_error_o            (ptw_error_o),
    .itlb_miss_o            (itlb_miss_o),
    .dtlb_miss_o            (dtlb_miss_o),
    .itlb_update_valid_o    (itlb_update_valid_o),
    .dtlb_update_valid_o    (dtlb_update_valid_o)
  );

  ptw_pte_checker u_pte_checker (
    .pte_i      (pte),
    .level_i    (level),
    .is_instr_i (walking_instr_o),
    .is_store_i (lsu_is_store_i),
    .mxr_i      (mxr_i),
    .leaf_o     (leaf),
    .fault_o    (fault)
  );

  ptw_walk_context u_walk_context (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .start_i          (start),
    .start_instr_i    (start_instr),
    .start_vaddr_i    (start_vaddr),
    .asid_i           (asid_i),
    .pte_accept_i     (pte_accept),
    .pte_i            (pte),
    .level_i          (level),
    .vaddr_o          (walk_vaddr),
    .walking_instr_o  (walking_instr_o),
    .update_vpn_o     (update_vpn_o),
    .update_asid_o    (update_asid_o),
    .update_is_2m_o   (update_is_2m_o),
    .update_is_1g_o   (update_is_1g_o),
    .update_content_o (update_content_o)
  );

endmodule

// ==== testbench/ptw_mem_model.sv ====
/* Page-table memory for the walker testbench, one request at a time.
   Grant and read-valid come after random delays of 0 to 3 cycles */
module ptw_mem_model (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  ptw_pkg::paddr_t addr_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output ptw_pkg::pte_t   rdata_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // sparse image, loaded by the testbench from the golden file
  ptw_pkg::pte_t   image [ptw_pkg::paddr_t];
  ptw_pkg::paddr_t addr_q;
  int              gnt_wait;
  int              rvalid_wait;
  logic            dropped;

  initial begin
    void'($urandom(32'hba804ce0));
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_n_i && req_i) begin
        gnt_wait = $urandom_range(3, 0);
        dropped  = 1'b0;
        // a flush may pull the request before it is granted
        while (gnt_wait > 0 && !dropped) begin
          @(posedge clk_i);
          #1;
          gnt_wait--;
          if (!req_i) begin
            dropped = 1'b1;
          end
        end
        if (!dropped) begin
          gnt_o  = 1'b1;
          addr_q = addr_i;
          @(posedge clk_i);
          #1;
          gnt_o       = 1'b0;
          rvalid_wait = $urandom_range(3, 0);
          repeat (rvalid_wait) begin
            @(posedge clk_i);
            #1;
          end
          // unmapped addresses read as an invalid pte
          rvalid_o = 1'b1;
          rdata_o  = image.exists(addr_q) ? image[addr_q] : '0;
          @(posedge clk_i);
          #1;
          rvalid_o = 1'b0;
        end
      end
    end
  end

endmodule

// ==== testbench/tb_ptw_sv39.sv ====
/* Testbench for the Sv39 page-table walker. Loads the page tables and the
   test vectors from the golden file, runs each walk and checks its result */
`include "ptw_defs.svh"

module tb_ptw_sv39;
  timeunit 1ns;
  timeprecision 100ps;

  logic                clk_i;
  logic                rst_n_i;
  logic                flush_i;
  logic                enable_translation_i;
  logic                en_ld_st_translation_i;
  logic                lsu_is_store_i;
  logic                mxr_i;
  ptw_pkg::asid_t      asid_i;
  ptw_pkg::ppn_t       satp_ppn_i;
  logic                itlb_access_i;
  logic                itlb_hit_i;
  logic                dtlb_access_i;
  logic                dtlb_hit_i;
  ptw_pkg::vaddr_t     itlb_vaddr_i;
  ptw_pkg::vaddr_t     dtlb_vaddr_i;
  logic                mem_gnt_i;
  logic                mem_rvalid_i;
  ptw_pkg::pte_t       mem_rdata_i;
  logic                mem_req_o;
  ptw_pkg::paddr_t     mem_addr_o;
  logic                ptw_active_o;
  logic                walking_instr_o;
  logic                ptw_error_o;
  logic                itlb_miss_o;
  logic                dtlb_miss_o;
  logic                itlb_update_valid_o;
  logic                dtlb_update_valid_o;
  logic                update_is_2m_o;
  logic                update_is_1g_o;
  ptw_pkg::vpn_t       update_vpn_o;
  ptw_pkg::asid_t      update_asid_o;
  ptw_pkg::pte_t       update_content_o;

  // test vectors, one entry per t line of the golden file
  string               t_name[$];
  string               t_side[$];
  logic                t_store[$];
  logic                t_mxr[$];
  ptw_pkg::vaddr_t     t_vaddr[$];
  string               t_outcome[$];
  int                  t_size[$];
  ptw_pkg::pte_t       t_content[$];

  int                  errors;
  int                  cycles;
  int                  cycle_limit;
  logic                limit_set;

  ptw_sv39 dut (.*);

  ptw_mem_model u_mem (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (mem_req_o),
    .addr_i   (mem_addr_o),
    .gnt_o    (mem_gnt_i),
    .rvalid_o (mem_rvalid_i),
    .rdata_o  (mem_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // watchdog, 200 cycles per test
  initial begin
    cycles = 0;
    wait (limit_set);
    while (cycles <= cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles without finishing", cycles);
    $display("Checks failed");
    $finish;
  end

  task automatic report_mismatch(input string test, input string what,
                                 input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("error %s %s expected %h actual %h", test, what, exp, act);
  endtask

  // ----------------------------------------------------------------------
  // golden file
  // ----------------------------------------------------------------------
  task automatic read_golden();
    int              fd;
    int              n;
    int              store;
    int              mxr;
    int              size;
    string           line;
    string           name;
    string           side;
    string           outcome;
    ptw_pkg::paddr_t addr;
    ptw_pkg::pte_t   data;
    ptw_pkg::vaddr_t vaddr;
    fd = $fopen("testbench/ptw_golden.dat", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open testbench/ptw_golden.dat");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 0 && line.getc(0) == "m") begin
          n = $sscanf(line, "m %h %h", addr, data);
          if (n == 2) begin
            u_mem.image[addr] = data;
          end else begin
            errors++;
            $display("malformed memory line in the golden file: %s", line);
          end
        end else if (line.len() > 0 && line.getc(0) == "t") begin
          n = $sscanf(line, "t %s %s %d %d %h %s %d %h",
                      name, side, store, mxr, vaddr, outcome, size, data);
          if (n == 8) begin
            t_name.push_back(name);
            t_side.push_back(side);
            t_store.push_back(store != 0);
            t_mxr.push_back(mxr != 0);
            t_vaddr.push_back(vaddr);
            t_outcome.push_back(outcome);
            t_size.push_back(size);
            t_content.push_back(data);
          end else begin
            errors++;
            $display("malformed test line in the golden file: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // fields of the update pulse against the golden row
  task automatic check_update(input int idx, input ptw_pkg::asid_t asid);
    string           name;
    logic [1:0]      exp_side;
    logic [1:0]      exp_size;
    ptw_pkg::vaddr_t va;
    name     = t_name[idx];
    va       = t_vaddr[idx];
    exp_side = (t_side[idx] == "i") ? 2'b10 : 2'b01;
    exp_size = {t_size[idx] == 2, t_size[idx] == 1};
    if ({itlb_update_valid_o, dtlb_update_valid_o} !== exp_side)
      report_mismatch(name, "update side", 64'(exp_side),
                      64'({itlb_update_valid_o, dtlb_update_valid_o}));
    if (walking_instr_o !== (t_side[idx] == "i"))
      report_mismatch(name, "walking instr", 64'(t_side[idx] == "i"), 64'(walking_instr_o));
    if (update_vpn_o !== va[`PTW_VLEN-1:`PTW_PGOFF])
      report_mismatch(name, "vpn", 64'(va[`PTW_VLEN-1:`PTW_PGOFF]), 64'(update_vpn_o));
    if ({update_is_1g_o, update_is_2m_o} !== exp_size)
      report_mismatch(name, "size", 64'(exp_size), 64'({update_is_1g_o, update_is_2m_o}));
    if (update_asid_o !== asid)
      report_mismatch(name, "asid", 64'(asid), 64'(update_asid_o));
    if (update_content_o !== t_content[idx])
      report_mismatch(name, "content", t_content[idx], update_content_o);
  endtask

  // ----------------------------------------------------------------------
  // one walk, from the miss to the update, the fault or the flush
  // ----------------------------------------------------------------------
  task automatic run_test(input int idx);
    string          name;
    string          side;
    string          actual;
    logic           saw_imiss;
    logic           saw_dmiss;
    logic           saw_update;
    logic           saw_error;
    logic           done;
    logic           rvalid_prev;
    logic           drained;
    ptw_pkg::asid_t asid;
    name        = t_name[idx];
    side        = t_side[idx];
    asid        = 16'h0100 + idx[15:0];
    saw_imiss   = 1'b0;
    saw_dmiss   = 1'b0;
    saw_update  = 1'b0;
    saw_error   = 1'b0;
    done        = 1'b0;
    rvalid_prev = 1'b0;
    drained     = 1'b0;
    @(posedge clk_i);
    #1;
    asid_i         = asid;
    lsu_is_store_i = t_store[idx];
    mxr_i          = t_mxr[idx];
    // side b raises both misses at once
    itlb_access_i  = (side != "d");
    itlb_vaddr_i   = t_vaddr[idx];
    dtlb_access_i  = (side != "i");
    dtlb_vaddr_i   = t_vaddr[idx];
    while (!done) begin
      @(negedge clk_i);
      if (itlb_miss_o)
        saw_imiss = 1'b1;
      if (dtlb_miss_o)
        saw_dmiss = 1'b1;
      if (itlb_update_valid_o || dtlb_update_valid_o) begin
        saw_update = 1'b1;
        done       = 1'b1;
        check_update(idx, asid);
      end else if (ptw_error_o) begin
        saw_error = 1'b1;
        done      = 1'b1;
      end else if (t_outcome[idx] == "f" && mem_req_o && mem_gnt_i) begin
        // next cycle is the first lookup, its response is still owed
        @(posedge clk_i);
        #1;
        flush_i       = 1'b1;
        itlb_access_i = 1'b0;
        dtlb_access_i = 1'b0;
        @(negedge clk_i);
        rvalid_prev = mem_rvalid_i;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        do begin
          @(negedge clk_i);
          // still busy in the cycle after the response, while it drains
          if (rvalid_prev && ptw_active_o)
            drained = 1'b1;
          rvalid_prev = mem_rvalid_i;
          if (itlb_update_valid_o || dtlb_update_valid_o)
            saw_update = 1'b1;
          if (ptw_error_o)
            saw_error = 1'b1;
        end while (ptw_active_o);
        if (!drained) begin
          errors++;
          $display("%s: walker went idle without draining the owed response", name);
        end
        done = 1'b1;
      end
    end
    @(posedge clk_i);
    #1;
    itlb_access_i  = 1'b0;
    dtlb_access_i  = 1'b0;
    lsu_is_store_i = 1'b0;
    mxr_i          = 1'b0;
    // walker idles the cycle after its last pulse
    @(negedge clk_i);
    if (ptw_active_o !== 1'b0)
      report_mismatch(name, "active after end", 64'd0, 64'(ptw_active_o));
    actual = saw_update ? "u" : (saw_error ? "e" : "f");
    if (actual != t_outcome[idx]) begin
      errors++;
      $display("error %s outcome expected %s actual %s", name, t_outcome[idx], actual);
    end
    if (saw_imiss !== (side == "i"))
      report_mismatch(name, "itlb miss", 64'(side == "i"), 64'(saw_imiss));
    if (saw_dmiss !== (side != "i"))
      report_mismatch(name, "dtlb miss", 64'(side != "i"), 64'(saw_dmiss));
  endtask

  initial begin
    rst_n_i                = 1'b0;
    flush_i                = 1'b0;
    enable_translation_i   = 1'b1;
    en_ld_st_translation_i = 1'b1;
    lsu_is_store_i         = 1'b0;
    mxr_i                  = 1'b0;
    asid_i                 = '0;
    satp_ppn_i             = 44'h80000;
    itlb_access_i          = 1'b0;
    itlb_hit_i             = 1'b0;
    dtlb_access_i          = 1'b0;
    dtlb_hit_i             = 1'b0;
    itlb_vaddr_i           = '0;
    dtlb_vaddr_i           = '0;
    errors                 = 0;
    limit_set              = 1'b0;
    read_golden();
    if (t_name.size() == 0) begin
      errors++;
      $display("no test vectors found in the golden file");
    end
    cycle_limit = 200 * t_name.size() + 10;
    limit_set   = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    if ({mem_req_o, ptw_active_o, ptw_error_o, itlb_miss_o, dtlb_miss_o,
         itlb_update_valid_o, dtlb_update_valid_o} !== 7'b0)
      report_mismatch("reset", "idle outputs", 64'd0,
                      64'({mem_req_o, ptw_active_o, ptw_error_o, itlb_miss_o,
                           dtlb_miss_o, itlb_update_valid_o, dtlb_update_valid_o}));
    for (int i = 0; i < t_name.size(); i++) begin
      run_test(i);
    end
    $display("%0d tests run, %0d errors", t_name.size(), errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== ptw_sv39.f ====
+incdir+include
design/ptw_pkg.sv
design/ptw_pte_checker.sv
design/ptw_walk_ctrl.sv
design/ptw_walk_context.sv
design/ptw_sv39.sv
testbench/ptw_mem_model.sv
testbench/tb_ptw_sv39.sv

// ==== Makefile ====
# Verilator build and run of the Sv39 page-table walker testbench

VERILATOR ?= verilator
TOP       ?= tb_ptw_sv39
FILELIST  ?= ptw_sv39.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/ptw_golden.dat ====
# m <pte paddr> <pte>    page-table image, hex
# t <name> <side i/d/b> <store> <mxr> <vaddr> <outcome u/e/f> <size 0=4K 1=2M 2=1G> <content>
# root table at satp ppn 80000
m 80000000 0000000020000401
m 80000008 00000000300000cf
m 80000010 00000000300004cf
m 80000018 0000000020000c21
# second level tables
m 80001000 0000000020000801
m 80001008 0000000020080043
m 80003000 0000000020001001
# third level tables
m 80002008 000000002400004b
m 80002010 00000000240004c7
m 80002018 0000000024000c49
m 80002020 0000000024001047
m 80002028 000000002400140b
m 80002030 0000000000000000
m 80002038 0000000020000801
m 80004000 0000000024004043
t walk_4k       i 0 0 0000001000 u 0 000000002400004b
t store_4k      d 1 0 0000002000 u 0 00000000240004c7
t leaf_1g       i 0 0 0040000000 u 2 00000000300000cf
t leaf_2m       d 0 0 0000200000 u 1 0000000020080043
t misalign_1g   i 0 0 0080000000 e 0 0000000000000000
t exec_only     d 0 0 0000003000 e 0 0000000000000000
t exec_only_mxr d 0 1 0000003000 u 0 0000000024000c49
t store_clean   d 1 0 0000004000 e 0 0000000000000000
t no_access     i 0 0 0000005000 e 0 0000000000000000
t invalid       d 0 0 0000006000 e 0 0000000000000000
t ptr_lvl3      i 0 0 0000007000 e 0 0000000000000000
t global        d 0 0 00c0000000 u 0 0000000024004063
t arbitrate     b 0 0 0000001000 u 0 000000002400004b
t flush         i 0 0 0000001000 f 0 0000000000000000
t after_flush   i 0 0 0000001000 u 0 000000002400004b
